// ==== verilog/line_xfer_macros.svh ====
// line transfer parameters
// bus size codes, line and beat widths, flash region and store depths
`ifndef LINE_XFER_MACROS_SVH
`define LINE_XFER_MACROS_SVH

// bus size codes, log2 of bytes per block
`define LX_SIZE_W 3'd2        // 4-byte beat
`define LX_SIZE_D 3'd3        // 8-byte beat

// line and narrow beat widths
`define LX_LINE_BITS 512
`define LX_WORD_BITS 32

// address bits 31:28 of the flash window
`define LX_FLASH_TAG 4'h3

// narrow beats per line
`define LX_FLASH_BEATS 16

// responder stores
`define LX_MEM_LINES 16       // indexed by addr 9:6
`define LX_FLASH_WORDS 64     // indexed by addr 7:2

// cycles from valid, or from the last handshake, to ready
`define LX_SLAVE_DELAY 2

`endif

// ==== verilog/line_xfer_pkg.sv ====
// line transfer types
// address and data vectors, cache and bus request/response structs, FSM states
package line_xfer_pkg;

  `include "line_xfer_macros.svh"

  typedef logic [63:0]                addr_t;      // byte address
  typedef logic [`LX_LINE_BITS-1:0]   line_t;      // one cache line
  typedef logic [`LX_WORD_BITS-1:0]   word_t;      // one flash word
  typedef logic [3:0]                 beat_cnt_t;  // flash beat index

  // cache side, driven by a cache controller
  typedef struct packed {
    logic   req;
    logic   op;     // 0 read, 1 write
    addr_t  addr;
    line_t  wdata;
  } line_req_t;

  typedef struct packed {
    logic   ack;    // one-cycle pulse
    line_t  rdata;
  } line_rsp_t;

  // memory bus side
  typedef struct packed {
    logic        valid;
    logic        op;
    addr_t       addr;
    line_t       wdata;
    logic [2:0]  size;
    logic [7:0]  blks;    // block count minus one
  } io_req_t;

  typedef struct packed {
    logic   ready;
    line_t  rdata;
  } io_rsp_t;

  typedef enum logic [1:0] {IDLE, BUSY, DONE} xfer_state_t;

  typedef enum logic [1:0] {NONE, DCACHE, ICACHE} arb_owner_t;

endpackage

// ==== verilog/line_port_arbiter.sv ====
// line port arbiter
// fixed priority, data cache first; grant locked until the line ack
`timescale 1ns/1ps

module line_port_arbiter import line_xfer_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  line_req_t  i_dcache,
  input  line_req_t  i_icache,
  output line_rsp_t  o_dcache,
  output line_rsp_t  o_icache,
  output line_req_t  o_req,
  input  line_rsp_t  i_rsp
);

  arb_owner_t owner_q;
  arb_owner_t grant;
  logic       hold_q;        // forces one low req cycle after ack
  line_t      dc_rdata_q;
  line_t      ic_rdata_q;

  // new grant only when free and not in the gap after ack
  always_comb begin
    grant = owner_q;
    if (owner_q == NONE && !hold_q) begin
      if (i_dcache.req) begin
        grant = DCACHE;
      end else if (i_icache.req) begin
        grant = ICACHE;
      end
    end
  end

  always_comb begin
    case (grant)
      DCACHE: o_req = i_dcache;
      ICACHE: o_req = i_icache;
      default: begin
        o_req     = i_dcache;
        o_req.req = 1'b0;    // nobody owns the sequencer
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      owner_q    <= NONE;
      hold_q     <= 1'b0;
      dc_rdata_q <= '0;
      ic_rdata_q <= '0;
    end else begin
      hold_q <= i_rsp.ack;
      if (i_rsp.ack) begin
        owner_q <= NONE;     // release on ack
        if (owner_q == DCACHE) dc_rdata_q <= i_rsp.rdata;
        if (owner_q == ICACHE) ic_rdata_q <= i_rsp.rdata;
      end else begin
        owner_q <= grant;
      end
    end
  end

  // ack and fresh data only to the owner, the other port keeps its last line
  always_comb begin
    o_dcache.ack   = i_rsp.ack & (owner_q == DCACHE);
    o_dcache.rdata = o_dcache.ack ? i_rsp.rdata : dc_rdata_q;
    o_icache.ack   = i_rsp.ack & (owner_q == ICACHE);
    o_icache.rdata = o_icache.ack ? i_rsp.rdata : ic_rdata_q;
  end

endmodule

// ==== verilog/cache_line_axi.sv ====
// cache line bus sequencer
// one wide beat for main memory, sixteen 32-bit beats for the flash window
`timescale 1ns/1ps

`include "line_xfer_macros.svh"

module cache_line_axi import line_xfer_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  line_req_t  i_req,
  output line_rsp_t  o_rsp,
  output io_req_t    o_io,
  input  io_rsp_t    i_io
);

  xfer_state_t state_q;
  logic        req_q;        // req history for edge detect
  logic        start;
  logic        hs;
  logic        is_flash;
  logic        flash_q;
  logic        op_q;
  logic        valid_q;
  logic        ack_q;
  addr_t       addr_q;
  line_t       wdata_q;
  line_t       rdata_q;
  beat_cnt_t   beat_q;
  beat_cnt_t   beat_nxt;
  word_t       rd_word;
  word_t       wr_word_nxt;

  assign start    = i_req.req & ~req_q;
  assign hs       = valid_q & i_io.ready;
  assign is_flash = (i_req.addr[31:28] == `LX_FLASH_TAG);
  assign beat_nxt = beat_q + beat_cnt_t'(1);

  assign rd_word     = i_io.rdata[`LX_WORD_BITS-1:0];          // narrow data in low lane
  assign wr_word_nxt = i_req.wdata[int'(beat_nxt) * `LX_WORD_BITS +: `LX_WORD_BITS];

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      req_q   <= 1'b0;
      valid_q <= 1'b0;
      ack_q   <= 1'b0;
      flash_q <= 1'b0;
      beat_q  <= '0;
      rdata_q <= '0;
    end else begin
      req_q <= i_req.req;
      ack_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start) begin
            flash_q <= is_flash;
            op_q    <= i_req.op;
            beat_q  <= '0;
            valid_q <= 1'b1;
            state_q <= BUSY;
            if (is_flash) begin
              addr_q  <= i_req.addr & ~64'h3;       // word aligned
              wdata_q <= line_t'(i_req.wdata[`LX_WORD_BITS-1:0]);
            end else begin
              addr_q  <= i_req.addr & ~64'h3f;      // line aligned
              wdata_q <= i_req.wdata;
            end
          end
        end
        BUSY: begin
          if (hs && !flash_q) begin
            rdata_q <= i_io.rdata;                  // whole line at once
            ack_q   <= 1'b1;
            valid_q <= 1'b0;
            state_q <= DONE;
          end else if (hs) begin
            rdata_q[int'(beat_q) * `LX_WORD_BITS +: `LX_WORD_BITS] <= rd_word;
            if (beat_q == beat_cnt_t'(`LX_FLASH_BEATS - 1)) begin
              ack_q   <= 1'b1;
              valid_q <= 1'b0;
              state_q <= DONE;
            end else begin
              addr_q  <= addr_q + 64'd4;
              wdata_q <= line_t'(wr_word_nxt);      // write word tracks the beat
              beat_q  <= beat_nxt;
            end
          end
        end
        default: state_q <= IDLE;                   // DONE, ack cycle
      endcase
    end
  end

  assign o_rsp = '{ack: ack_q, rdata: rdata_q};

  // flash is single 4-byte beats, memory an 8 x 8-byte burst
  assign o_io = '{
    valid: valid_q,
    op:    op_q,
    addr:  addr_q,
    wdata: wdata_q,
    size:  flash_q ? `LX_SIZE_W : `LX_SIZE_D,
    blks:  flash_q ? 8'd0 : 8'd7
  };

endmodule

// ==== verilog/io_slave_mem.sv ====
// bus responder model
// wide main memory plus narrow flash store, ready after a fixed delay
`timescale 1ns/1ps

`include "line_xfer_macros.svh"

module io_slave_mem import line_xfer_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  io_req_t  i_io,
  output io_rsp_t  o_io
);

  localparam int CNT_W = $clog2(`LX_SLAVE_DELAY + 1);

  line_t             mem_q   [`LX_MEM_LINES];
  word_t             flash_q [`LX_FLASH_WORDS];
  logic [CNT_W-1:0]  cnt_q;
  logic              ready_q;
  logic              hs;
  logic              is_word;
  logic [3:0]        line_idx;
  logic [5:0]        word_idx;
  line_t             rd_line;

  assign hs       = i_io.valid & ready_q;
  assign is_word  = (i_io.size == `LX_SIZE_W);
  assign line_idx = i_io.addr[9:6];
  assign word_idx = i_io.addr[7:2];

  // ready pulse, restarts the count after every handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q <= 1'b0;
      cnt_q   <= '0;
    end else if (ready_q) begin
      ready_q <= 1'b0;
      cnt_q   <= '0;
    end else if (i_io.valid) begin
      if (cnt_q == CNT_W'(`LX_SLAVE_DELAY - 1)) begin
        ready_q <= 1'b1;
        cnt_q   <= '0;
      end else begin
        cnt_q <= cnt_q + CNT_W'(1);
      end
    end else begin
      cnt_q <= '0;
    end
  end

  // stores, written on the handshake
  always_ff @(posedge clk) begin
    if (hs && i_io.op) begin
      if (is_word) begin
        flash_q[word_idx] <= i_io.wdata[`LX_WORD_BITS-1:0];
      end else begin
        mem_q[line_idx] <= i_io.wdata;
      end
    end
  end

  // read data in the ready cycle, narrow word in the low lane
  always_comb begin
    if (is_word) begin
      rd_line = line_t'(flash_q[word_idx]);
    end else begin
      rd_line = mem_q[line_idx];
    end
  end

  assign o_io = '{ready: ready_q, rdata: rd_line};

endmodule

// ==== verilog/line_xfer_top.sv ====
// line transfer subsystem
// two cache ports, arbiter, line sequencer and bus responder
`timescale 1ns/1ps

module line_xfer_top import line_xfer_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  line_req_t  i_dcache,
  input  line_req_t  i_icache,
  output line_rsp_t  o_dcache,
  output line_rsp_t  o_icache
);

  line_req_t arb_req;   // granted port toward the sequencer
  line_rsp_t arb_rsp;
  io_req_t   io_req;
  io_rsp_t   io_rsp;

  line_port_arbiter u_arbiter (
    .clk      (clk),
    .rst      (rst),
    .i_dcache (i_dcache),
    .i_icache (i_icache),
    .o_dcache (o_dcache),
    .o_icache (o_icache),
    .o_req    (arb_req),
    .i_rsp    (arb_rsp)
  );

  cache_line_axi u_line_axi (
    .clk   (clk),
    .rst   (rst),
    .i_req (arb_req),
    .o_rsp (arb_rsp),
    .o_io  (io_req),
    .i_io  (io_rsp)
  );

  io_slave_mem u_slave_mem (
    .clk  (clk),
    .rst  (rst),
    .i_io (io_req),
    .o_io (io_rsp)
  );

endmodule

// ==== dv/tb_clk_gen.sv ====
// testbench clock and reset
// 20 ns clock, reset held high over the first two rising edges
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;   // 20 ns period
  end

  initial begin
    o_rst <= 1'b1;
    repeat (2) @(posedge o_clk);
    o_rst <= 1'b0;                // released on the second edge
  end

endmodule

// ==== dv/tb_line_xfer.sv ====
// line transfer testbench
// table of cache line requests checked against a model of memory and flash
`timescale 1ns/1ps

`include "line_xfer_macros.svh"

module tb_line_xfer import line_xfer_pkg::*; ();

  typedef struct packed {
    logic   port;   // 0 dcache, 1 icache
    logic   op;     // 0 read, 1 write
    logic   pair;   // starts in the same cycle as the next entry
    addr_t  addr;
  } entry_t;

  localparam int n_entries = 12;
  localparam int timeout_cycles =
    n_entries * `LX_FLASH_BEATS * (`LX_SLAVE_DELAY + 1) + 200;

  localparam entry_t xfer_table [n_entries] = '{
    '{1'b0, 1'b1, 1'b0, 64'h0000_0140},   // memory line 5
    '{1'b0, 1'b0, 1'b0, 64'h0000_0140},
    '{1'b0, 1'b0, 1'b0, 64'h0000_0167},   // low bits set within line 5
    '{1'b1, 1'b1, 1'b0, 64'h0000_0240},   // memory line 9
    '{1'b0, 1'b1, 1'b0, 64'h3000_0004},   // flash words 1 to 16
    '{1'b0, 1'b1, 1'b0, 64'h3000_0024},   // flash words 9 to 24
    '{1'b0, 1'b0, 1'b0, 64'h3000_0024},
    '{1'b1, 1'b0, 1'b0, 64'h3000_0008},   // overlaps both writes
    '{1'b0, 1'b1, 1'b1, 64'h0000_0240},
    '{1'b1, 1'b0, 1'b0, 64'h0000_0150},
    '{1'b0, 1'b0, 1'b1, 64'h3000_0026},
    '{1'b1, 1'b0, 1'b0, 64'h0000_0240}
  };

  logic        clk;
  logic        rst;
  line_req_t   dcache_req;
  line_req_t   icache_req;
  line_rsp_t   dcache_rsp;
  line_rsp_t   icache_rsp;
  line_t       mem_ref [`LX_MEM_LINES];
  word_t       flash_ref [`LX_FLASH_WORDS];
  logic        rd_flag [2];
  line_t       exp_line [2];
  int          exp_acks [2] = '{0, 0};
  int          acks [2] = '{0, 0};
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;
  int unsigned seed_ret;

  tb_clk_gen u_clk_gen (
    .o_clk (clk),
    .o_rst (rst)
  );

  line_xfer_top i_line_xfer_top (
    .clk      (clk),
    .rst      (rst),
    .i_dcache (dcache_req),
    .i_icache (icache_req),
    .o_dcache (dcache_rsp),
    .o_icache (icache_rsp)
  );

  task automatic check(input string name, input line_t got, input line_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail %s got %h expected %h", name, got, want);
    end
  endtask

  // builds the request, updates the model and drives the port
  task automatic launch(input entry_t e);
    line_req_t  r;
    line_t      want;
    logic [5:0] widx;
    int         k;
    r    = '{req: 1'b1, op: e.op, addr: e.addr, wdata: '0};
    want = '0;
    if (e.op) begin
      for (k = 0; k < `LX_FLASH_BEATS; k++) begin
        r.wdata[k*`LX_WORD_BITS +: `LX_WORD_BITS] = $urandom;
      end
    end
    if (e.addr[31:28] == `LX_FLASH_TAG) begin
      // consecutive words from the word-aligned start
      for (k = 0; k < `LX_FLASH_BEATS; k++) begin
        widx = e.addr[7:2] + 6'(k);
        if (e.op) flash_ref[widx] = r.wdata[k*`LX_WORD_BITS +: `LX_WORD_BITS];
        want[k*`LX_WORD_BITS +: `LX_WORD_BITS] = flash_ref[widx];
      end
    end else begin
      if (e.op) mem_ref[e.addr[9:6]] = r.wdata;   // alignment keeps bits 9:6
      want = mem_ref[e.addr[9:6]];
    end
    rd_flag[e.port]  = ~e.op;
    exp_line[e.port] = want;
    exp_acks[e.port]++;
    if (e.port) icache_req <= r;
    else dcache_req <= r;
  endtask

  // waits for this port's ack, then drops req
  task automatic finish_xfer(input logic port);
    line_rsp_t own;
    line_rsp_t other;
    string     who;
    who = port ? "icache" : "dcache";
    do begin
      @(negedge clk);
      own   = port ? icache_rsp : dcache_rsp;
      other = port ? dcache_rsp : icache_rsp;
      if (other.ack) begin
        errors++;
        $display("an ack arrived on the other port while %s was waiting", who);
      end
    end while (!own.ack);
    if (rd_flag[port]) check({who, " rdata"}, own.rdata, exp_line[port]);
    @(posedge clk);
    if (port) icache_req.req <= 1'b0;
    else dcache_req.req <= 1'b0;
    @(negedge clk);
    own = port ? icache_rsp : dcache_rsp;
    check({who, " ack pulse"}, line_t'(own.ack), '0);
  endtask

  always @(negedge clk) begin
    if (!rst && dcache_rsp.ack) acks[0] <= acks[0] + 1;
    if (!rst && icache_rsp.ack) acks[1] <= acks[1] + 1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, a transfer never completed", cycles);
      $display("checks %0d, errors %0d", checks, errors + 1);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    int     i;
    entry_t e;
    dcache_req <= '0;
    icache_req <= '0;
    seed_ret = $urandom(32'h000a_3b2d);
    @(negedge rst);                          // end of the reset pulse
    // idle ports right after reset
    repeat (4) begin
      @(negedge clk);
      check("dcache ack", line_t'(dcache_rsp.ack), '0);
      check("icache ack", line_t'(icache_rsp.ack), '0);
      check("dcache rdata", dcache_rsp.rdata, '0);
      check("icache rdata", icache_rsp.rdata, '0);
    end
    for (i = 0; i < n_entries; i++) begin
      @(posedge clk);
      e = xfer_table[i];
      launch(e);
      if (e.pair) launch(xfer_table[i + 1]);
      finish_xfer(e.port);                   // dcache served first in a pair
      if (e.pair) begin
        i++;
        finish_xfer(xfer_table[i].port);
      end
    end
    check("dcache ack count", line_t'(acks[0]), line_t'(exp_acks[0]));
    check("icache ack count", line_t'(acks[1]), line_t'(exp_acks[1]));
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/line_xfer_pkg.sv
verilog/line_port_arbiter.sv
verilog/cache_line_axi.sv
verilog/io_slave_mem.sv
verilog/line_xfer_top.sv
dv/tb_clk_gen.sv
dv/tb_line_xfer.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the line transfer testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f list.f \
  --top-module tb_line_xfer -o sim_line_xfer
./obj_dir/sim_line_xfer | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
